// ==== jtpopeye_rom_loader.f ====
verilog/jtpopeye_rom_pkg.sv
verilog/jtpopeye_rom_route.sv
verilog/jtpopeye_xfer_cdc.sv
verilog/jtpopeye_prom_bank.sv
verilog/jtpopeye_crypt_detect.sv
verilog/jtpopeye_rom_loader.sv
testbench/tb_rom_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; $fatal gives a failing exit status
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
    --top-module tb_rom_loader -f jtpopeye_rom_loader.f \
    --Mdir obj_dir -o tb_rom_loader \
    && ./obj_dir/tb_rom_loader \
    || { echo "simulation failed"; exit 1; }
echo "simulation passed"

// ==== testbench/tb_rom_loader.sv ====
`timescale 1ns/1ps

module tb_rom_loader import jtpopeye_rom_pkg::*; ();

    localparam int KIND_SDRAM  = 0;
    localparam int KIND_PROM   = 1;
    localparam int KIND_DROP   = 2;
    localparam int TOTAL_BYTES = 4 + 10 + 5 + 8 + 200; // Bytes over all tests
    localparam int WATCHDOG_NS = TOTAL_BYTES * 40 * 10 + 2000;

    logic               clk_rom = 1'b0;
    logic               clk_rgb = 1'b0;
    logic               rst;
    logic               downloading;
    logic [21:0]        ioctl_addr;
    logic [7:0]         ioctl_data;
    logic               ioctl_wr;
    prom_id_e           rd_id;
    logic [PROM_AW-1:0] rd_addr;
    sdram_prog_t        prog;
    logic               prog_we;
    logic [7:0]         rd_data;
    logic               load_done;
    load_status_t       load_status;

    logic [7:0]         shadow [0:PROM_COUNT-1][0:8191]; // Expected PROM contents
    prom_id_e           written_id[$];                   // Locations to read back
    logic [PROM_AW-1:0] written_off[$];
    logic [15:0]        exp_drops;                       // Drops in this download
    logic [3:0]         exp_match;                       // Signature bytes seen correct
    logic               sig_armed;
    int                 we_count = 0;                    // prog_we pulses seen
    logic [31:0]        rng_state = 32'hf35b;
    string              test_name = "reset";

    always #5 clk_rom = ~clk_rom;  // 10 ns loader clock
    always #20 clk_rgb = ~clk_rgb; // 40 ns video clock

    jtpopeye_rom_loader i_jtpopeye_rom_loader (.*);

    always @(negedge clk_rom) begin
        if (prog_we) begin
            we_count <= we_count + 1; // Sampled mid cycle
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_error("timeout: the tests did not finish within the watchdog limit");
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [7:0] sig_byte(input logic [1:0] idx);
        case (idx)
            2'd0:    return CRYPT_SIG0;
            2'd1:    return CRYPT_SIG1;
            2'd2:    return CRYPT_SIG2;
            default: return CRYPT_SIG3;
        endcase
    endfunction

    function automatic load_status_t make_status(input logic enc, input logic [15:0] drops);
        load_status_t s;
        s.encrypted = enc;
        s.dropped   = drops;
        return s;
    endfunction

    // Address map reference, one rule per branch
    function automatic int classify(input logic [21:0] a, output prom_id_e id,
                                    output logic [PROM_AW-1:0] off);
        id  = PROM_TIMING_7J;
        off = '0;
        if (a < SDRAM_LIMIT) return KIND_SDRAM;
        if (a[21:17] != 5'd0) return KIND_DROP;
        if (!a[16]) begin
            case (a[15:13])
                3'd4:    id = PROM_OBJ_0;
                3'd5:    id = PROM_OBJ_1;
                3'd6:    id = PROM_OBJ_2;
                default: id = PROM_OBJ_3; // Only 7 left, bit 15 is set here
            endcase
            off = a[12:0];
            return KIND_PROM;
        end
        if (a[12:11] == 2'b01) begin
            id  = PROM_TXT_5N;
            off = {2'd0, a[10:0]};
            return KIND_PROM;
        end
        if (a[12:11] == 2'b00) return KIND_DROP; // Discarded text half
        case (a[9:8])
            2'd0:    id = PROM_TIMING_7J;
            2'd1:    id = PROM_OBJPAL_5B;
            2'd2:    id = PROM_OBJPAL_5A;
            default: id = a[5] ? PROM_BACKPAL_4A : PROM_TXTPAL_3A;
        endcase
        off = (a[9:8] == 2'd3) ? {8'd0, a[4:0]} : {5'd0, a[7:0]};
        return KIND_PROM;
    endfunction

    task automatic check_prog(input sdram_prog_t exp, input sdram_prog_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("mismatch %s: prog expected %h/%h/%b, actual %h/%h/%b",
                test_name, exp.addr, exp.data, exp.mask, act.addr, act.data, act.mask));
        end
    endtask

    // Starts at clk_rgb edge plus 1 ns and ends there
    task automatic check_prom(input prom_id_e id, input logic [PROM_AW-1:0] off,
                              input logic [7:0] exp);
        rd_id   = id;
        rd_addr = off;
        @(posedge clk_rgb);
        #1;
        if (rd_data !== exp) begin
            stop_with_error($sformatf("mismatch %s: %s[%h] expected %h, actual %h",
                test_name, id.name(), off, exp, rd_data));
        end
    endtask

    task automatic check_status(input load_status_t exp, input load_status_t act);
        if (act !== exp) begin
            stop_with_error($sformatf(
                "mismatch %s: status expected enc %b drop %0d, actual enc %b drop %0d",
                test_name, exp.encrypted, exp.dropped, act.encrypted, act.dropped));
        end
    endtask

    task automatic start_download();
        @(posedge clk_rom);
        #1;
        downloading = 1'b1;
        exp_drops   = 16'd0;
        exp_match   = 4'd0;
        sig_armed   = 1'b1;
        repeat (2) @(posedge clk_rom);
    endtask

    task automatic end_download(input load_status_t exp);
        int waited;
        waited = 0;
        @(posedge clk_rom);
        #1;
        downloading = 1'b0;
        @(negedge clk_rgb);
        while (!load_done && waited < 10) begin
            @(negedge clk_rgb);
            waited++;
        end
        if (!load_done) begin
            stop_with_error(
                "load_done did not pulse within 10 clk_rgb cycles of the end of the download");
        end
        check_status(exp, load_status);
        @(negedge clk_rgb);
        if (load_done) begin
            stop_with_error("load_done stayed high for more than one clk_rgb cycle");
        end
    endtask

    // One strobe, model update, SDRAM port check
    task automatic send_byte(input logic [21:0] addr, input logic [7:0] data);
        int                 kind;
        int                 we_before;
        prom_id_e           id;
        logic [PROM_AW-1:0] off;
        sdram_prog_t        exp_prog;
        kind      = classify(addr, id, off);
        we_before = we_count;
        @(posedge clk_rom);
        #1;
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(posedge clk_rom);
        #1;
        ioctl_wr = 1'b0;
        if (kind == KIND_SDRAM) begin
            if (prog_we !== 1'b1) begin
                stop_with_error($sformatf("prog_we missing one clk_rom cycle after byte %h", addr));
            end
            exp_prog.addr = addr >> 1;                   // Word address
            exp_prog.data = data;
            exp_prog.mask = addr[0] ? 2'b01 : 2'b10;     // Active low lane enable
            check_prog(exp_prog, prog);
        end else if (kind == KIND_PROM) begin
            shadow[id][off] = data;
            written_id.push_back(id);
            written_off.push_back(off);
        end else begin
            exp_drops = exp_drops + 16'd1;
        end
        if (sig_armed && addr[21:2] == 20'd0) begin
            exp_match[addr[1:0]] = (data == sig_byte(addr[1:0]));
            if (addr[1:0] == 2'd3) sig_armed = 1'b0; // Last signature byte
        end
        repeat (32) @(posedge clk_rom);
        if (we_count != we_before + ((kind == KIND_SDRAM) ? 1 : 0)) begin
            stop_with_error($sformatf("mismatch %s: prog_we pulses for %h expected %0d, actual %0d",
                test_name, addr, (kind == KIND_SDRAM) ? 1 : 0, we_count - we_before));
        end
    endtask

    task automatic verify_proms();
        @(posedge clk_rgb);
        #1;
        foreach (written_id[i]) begin
            check_prom(written_id[i], written_off[i], shadow[written_id[i]][written_off[i]]);
        end
    endtask

    task automatic sdram_bytes();
        test_name = "sdram_bytes";
        start_download();
        send_byte(22'h000000, 8'h3c); // Even
        send_byte(22'h000001, 8'hc3); // Odd
        send_byte(22'h001235, 8'h5a);
        send_byte(22'h007ffe, 8'ha7); // Last even word below the limit
        end_download(make_status(&exp_match, exp_drops));
    endtask

    task automatic prom_targets();
        test_name = "prom_targets";
        start_download();
        send_byte(22'h008012, 8'(next_rand())); // OBJ_0
        send_byte(22'h00babc, 8'(next_rand())); // OBJ_1
        send_byte(22'h00c345, 8'(next_rand())); // OBJ_2
        send_byte(22'h00ffff, 8'(next_rand())); // OBJ_3
        send_byte(22'h010fa5, 8'(next_rand())); // TXT_5N
        send_byte(22'h01103c, 8'(next_rand())); // TIMING_7J
        send_byte(22'h011181, 8'(next_rand())); // OBJPAL_5B
        send_byte(22'h0112fe, 8'(next_rand())); // OBJPAL_5A
        send_byte(22'h01130d, 8'(next_rand())); // TXTPAL_3A, bit 5 clear
        send_byte(22'h011331, 8'(next_rand())); // BACKPAL_4A, bit 5 set
        end_download(make_status(&exp_match, exp_drops));
        verify_proms();
    endtask

    task automatic dropped_bytes();
        test_name = "dropped_bytes";
        start_download();
        send_byte(22'h010923, 8'h5c); // TXT_5N offset 123
        send_byte(22'h010123, 8'hff); // Same offset in the discarded half
        send_byte(22'h0107ff, 8'h11);
        send_byte(22'h020923, 8'h22); // Bit 17 set
        send_byte(22'h3fffff, 8'h33);
        end_download(make_status(1'b0, 16'd4));
        verify_proms();
    endtask

    task automatic signature();
        test_name = "signature_match";
        start_download();
        send_byte(22'h000000, 8'he4);
        send_byte(22'h000001, 8'h64);
        send_byte(22'h000002, 8'ha5);
        send_byte(22'h000003, 8'h46);
        end_download(make_status(1'b1, 16'd0));
        test_name = "signature_miss";
        start_download();
        send_byte(22'h000000, 8'he4);
        send_byte(22'h000001, 8'h64);
        send_byte(22'h000002, 8'h5a); // Third byte wrong
        send_byte(22'h000003, 8'h46);
        end_download(make_status(1'b0, 16'd0));
    endtask

    task automatic random_sweep();
        logic [31:0] r;
        logic [21:0] addr;
        test_name = "random_sweep";
        start_download();
        for (int i = 0; i < 200; i++) begin
            r = next_rand();
            case (r[17:16])
                2'd0:    addr = {7'd0, r[14:0]};                 // SDRAM code
                2'd1:    addr = 22'h008000 | {7'd0, r[14:0]};    // OBJ PROMs
                2'd2:    addr = 22'h010800 | {11'd0, r[10:0]};   // Text PROM
                default: addr = 22'h011000 | {12'd0, r[9:0]};    // Timing and palettes
            endcase
            send_byte(addr, r[31:24]);
        end
        end_download(make_status(&exp_match, exp_drops));
        verify_proms();
    endtask

    initial begin
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        rd_id       = PROM_TIMING_7J;
        rd_addr     = '0;
        exp_drops   = '0;
        exp_match   = '0;
        sig_armed   = 1'b0;
        repeat (3) @(posedge clk_rgb);
        #1;
        rst = 1'b0;
        sdram_bytes();
        prom_targets();
        dropped_bytes();
        signature();
        random_sweep();
        $display("No errors");
        $finish;
    end

endmodule

// ==== verilog/jtpopeye_crypt_detect.sv ====
`timescale 1ns/1ps

module jtpopeye_crypt_detect import jtpopeye_rom_pkg::*; (
    input  logic         clk_rom,
    input  logic         rst,
    input  logic         downloading,
    input  logic [21:0]  ioctl_addr,
    input  logic [7:0]   ioctl_data,
    input  logic         ioctl_wr,
    input  logic         drop_stb,
    output load_status_t status,
    output logic         status_stb
);

    logic        dl_q;     // Downloading, one cycle late
    logic        dl_rise;  // Start of a download
    logic        fall_q;   // End of a download seen
    logic        armed;    // Waiting for the signature bytes
    logic        check;    // Signature byte on this cycle
    logic [3:0]  match;    // Per byte compare result
    logic [15:0] drop_cnt; // Bytes dropped so far
    logic [7:0]  sig_byte; // Expected byte for this address

    assign dl_rise = downloading && !dl_q;
    assign check   = (armed || dl_rise) && ioctl_wr && ioctl_addr[21:2] == 20'd0;

    always_comb begin
        case (ioctl_addr[1:0])
            2'd0:    sig_byte = CRYPT_SIG0;
            2'd1:    sig_byte = CRYPT_SIG1;
            2'd2:    sig_byte = CRYPT_SIG2;
            default: sig_byte = CRYPT_SIG3;
        endcase
    end

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            dl_q       <= 1'b0;
            fall_q     <= 1'b0;
            armed      <= 1'b0;
            match      <= 4'd0;
            drop_cnt   <= 16'd0;
            status     <= '0;
            status_stb <= 1'b0;
        end else begin
            dl_q       <= downloading;
            fall_q     <= dl_q && !downloading;
            status_stb <= fall_q; // Second cycle after the falling edge
            if (dl_rise) begin
                armed <= 1'b1;
                match <= 4'd0;
            end
            if (check) begin
                match[ioctl_addr[1:0]] <= ioctl_data == sig_byte;
                if (ioctl_addr[1:0] == 2'd3) begin
                    armed <= 1'b0; // Last signature byte
                end
            end
            if (dl_rise) begin
                drop_cnt <= 16'd0;
            end else if (drop_stb && drop_cnt != 16'hffff) begin
                drop_cnt <= drop_cnt + 16'd1; // Saturates
            end
            if (fall_q) begin
                status <= '{encrypted: &match, dropped: drop_cnt};
            end
        end
    end

endmodule

// ==== verilog/jtpopeye_prom_bank.sv ====
`timescale 1ns/1ps

module jtpopeye_prom_bank import jtpopeye_rom_pkg::*; (
    input  logic               clk_rgb,
    input  prom_wr_t           wr,
    input  logic               wr_stb,
    input  prom_id_e           rd_id,
    input  logic [PROM_AW-1:0] rd_addr,
    output logic [7:0]         rd_data
);

    logic [7:0] timing_7j  [0:255];        // Video timing
    logic [7:0] objpal_5b  [0:255];        // Object palette high
    logic [7:0] objpal_5a  [0:255];        // Object palette low
    logic [7:0] txtpal_3a  [0:31];         // Text palette
    logic [7:0] backpal_4a [0:31];         // Background palette
    logic [7:0] txt_5n     [0:2047];       // Text tiles
    logic [7:0] obj_rom    [0:3][0:8191];  // Four object PROMs

    logic [1:0] obj_wsel; // OBJ PROM for the write
    logic [1:0] obj_rsel; // OBJ PROM for the read

    assign obj_wsel = 2'(wr.id - PROM_OBJ_0);
    assign obj_rsel = 2'(rd_id - PROM_OBJ_0);

    // Write port, one byte per crossed request
    always_ff @(posedge clk_rgb) begin
        if (wr_stb) begin
            case (wr.id)
                PROM_TIMING_7J:  timing_7j[wr.offset[7:0]]  <= wr.data;
                PROM_OBJPAL_5B:  objpal_5b[wr.offset[7:0]]  <= wr.data;
                PROM_OBJPAL_5A:  objpal_5a[wr.offset[7:0]]  <= wr.data;
                PROM_TXTPAL_3A:  txtpal_3a[wr.offset[4:0]]  <= wr.data;
                PROM_BACKPAL_4A: backpal_4a[wr.offset[4:0]] <= wr.data;
                PROM_TXT_5N:     txt_5n[wr.offset[10:0]]    <= wr.data;
                PROM_OBJ_0,
                PROM_OBJ_1,
                PROM_OBJ_2,
                PROM_OBJ_3:      obj_rom[obj_wsel][wr.offset] <= wr.data;
                default: ; // No such PROM
            endcase
        end
    end

    // Registered read port for the video side
    always_ff @(posedge clk_rgb) begin
        case (rd_id)
            PROM_TIMING_7J:  rd_data <= timing_7j[rd_addr[7:0]];
            PROM_OBJPAL_5B:  rd_data <= objpal_5b[rd_addr[7:0]];
            PROM_OBJPAL_5A:  rd_data <= objpal_5a[rd_addr[7:0]];
            PROM_TXTPAL_3A:  rd_data <= txtpal_3a[rd_addr[4:0]];
            PROM_BACKPAL_4A: rd_data <= backpal_4a[rd_addr[4:0]];
            PROM_TXT_5N:     rd_data <= txt_5n[rd_addr[10:0]];
            PROM_OBJ_0,
            PROM_OBJ_1,
            PROM_OBJ_2,
            PROM_OBJ_3:      rd_data <= obj_rom[obj_rsel][rd_addr];
            default:         rd_data <= 8'h00;
        endcase
    end

    // Router decode must land inside the target
    a_in_range: assert property (@(posedge clk_rgb)
        wr_stb |-> (int'(wr.id) < PROM_COUNT) && (32'(wr.offset) < prom_depth(wr.id)))
        else $error("prom_bank: write outside PROM %0d", wr.id);

endmodule

// ==== verilog/jtpopeye_rom_loader.sv ====
`timescale 1ns/1ps

module jtpopeye_rom_loader import jtpopeye_rom_pkg::*; (
    input  logic               clk_rom,
    input  logic               clk_rgb,
    input  logic               rst,
    input  logic               downloading,
    input  logic [21:0]        ioctl_addr,
    input  logic [7:0]         ioctl_data,
    input  logic               ioctl_wr,
    input  prom_id_e           rd_id,
    input  logic [PROM_AW-1:0] rd_addr,
    output sdram_prog_t        prog,
    output logic               prog_we,
    output logic [7:0]         rd_data,
    output logic               load_done,
    output load_status_t       load_status
);

    prom_wr_t     prom_req;     // Router request, clk_rom
    logic         prom_req_stb;
    prom_wr_t     prom_wr;      // Crossed request, clk_rgb
    logic         prom_wr_stb;
    logic         drop_stb;     // Byte with no destination
    load_status_t status;       // Detector report, clk_rom
    logic         status_stb;

    jtpopeye_rom_route i_route (
        .clk_rom      (clk_rom),
        .rst          (rst),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .ioctl_wr     (ioctl_wr),
        .prog         (prog),
        .prog_we      (prog_we),
        .prom_req     (prom_req),
        .prom_req_stb (prom_req_stb),
        .drop_stb     (drop_stb)
    );

    jtpopeye_xfer_cdc #(.payload_t(prom_wr_t)) i_prom_cdc (
        .clk_rom (clk_rom),
        .clk_rgb (clk_rgb),
        .rst     (rst),
        .in      (prom_req),
        .in_stb  (prom_req_stb),
        .busy    (),            // Loader spacing stands in for flow control
        .out     (prom_wr),
        .out_stb (prom_wr_stb)
    );

    jtpopeye_prom_bank i_prom_bank (
        .clk_rgb (clk_rgb),
        .wr      (prom_wr),
        .wr_stb  (prom_wr_stb),
        .rd_id   (rd_id),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    jtpopeye_crypt_detect i_crypt (
        .clk_rom     (clk_rom),
        .rst         (rst),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .drop_stb    (drop_stb),
        .status      (status),
        .status_stb  (status_stb)
    );

    jtpopeye_xfer_cdc #(.payload_t(load_status_t)) i_status_cdc (
        .clk_rom (clk_rom),
        .clk_rgb (clk_rgb),
        .rst     (rst),
        .in      (status),
        .in_stb  (status_stb),
        .busy    (),            // One report per download
        .out     (load_status), // Held until the next download ends
        .out_stb (load_done)
    );

endmodule

// ==== verilog/jtpopeye_rom_pkg.sv ====
package jtpopeye_rom_pkg;

    // Download address map
    localparam logic [21:0] SDRAM_LIMIT = 22'd32768; // First address past the SDRAM code
    localparam int          PROM_COUNT  = 10;        // On-chip PROM targets
    localparam int          PROM_AW     = 13;        // Offset width, sized for the OBJ PROMs

    // Signature at the start of an encrypted set
    localparam logic [7:0] CRYPT_SIG0 = 8'he4;
    localparam logic [7:0] CRYPT_SIG1 = 8'h64;
    localparam logic [7:0] CRYPT_SIG2 = 8'ha5;
    localparam logic [7:0] CRYPT_SIG3 = 8'h46;

    // PROM targets, OBJ entries kept consecutive for the offset decode
    typedef enum logic [3:0] {
        PROM_TIMING_7J  = 4'd0, // Video timing
        PROM_OBJPAL_5B  = 4'd1, // Object palette high
        PROM_OBJPAL_5A  = 4'd2, // Object palette low
        PROM_TXTPAL_3A  = 4'd3, // Text palette
        PROM_BACKPAL_4A = 4'd4, // Background palette
        PROM_TXT_5N     = 4'd5, // Text tiles, second half of file
        PROM_OBJ_0      = 4'd6, // Object graphics
        PROM_OBJ_1      = 4'd7,
        PROM_OBJ_2      = 4'd8,
        PROM_OBJ_3      = 4'd9
    } prom_id_e;

    // Depth in bytes of each target
    function automatic int unsigned prom_depth(prom_id_e id);
        int unsigned depth;
        case (id)
            PROM_TIMING_7J,
            PROM_OBJPAL_5B,
            PROM_OBJPAL_5A:  depth = 256;
            PROM_TXTPAL_3A,
            PROM_BACKPAL_4A: depth = 32;
            PROM_TXT_5N:     depth = 2048;
            PROM_OBJ_0,
            PROM_OBJ_1,
            PROM_OBJ_2,
            PROM_OBJ_3:      depth = 8192;
            default:         depth = 0; // Unused codes 10 to 15
        endcase
        return depth;
    endfunction

    // SDRAM programming port word
    typedef struct packed {
        logic [21:0] addr; // Word address
        logic [7:0]  data; // Byte lane value
        logic [1:0]  mask; // Active low, bit 0 for the low byte
    } sdram_prog_t;

    // One PROM byte write
    typedef struct packed {
        prom_id_e           id;
        logic [PROM_AW-1:0] offset;
        logic [7:0]         data;
    } prom_wr_t;

    // End of download report
    typedef struct packed {
        logic        encrypted; // All four signature bytes matched
        logic [15:0] dropped;   // Bytes with no destination
    } load_status_t;

endpackage

// ==== verilog/jtpopeye_rom_route.sv ====
`timescale 1ns/1ps

module jtpopeye_rom_route import jtpopeye_rom_pkg::*; (
    input  logic        clk_rom,
    input  logic        rst,
    input  logic [21:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    output sdram_prog_t prog,
    output logic        prog_we,
    output prom_wr_t    prom_req,
    output logic        prom_req_stb,
    output logic        drop_stb
);

    logic               is_sdram;   // Program or graphics code
    logic               is_prom;    // One of the ten PROMs
    prom_id_e           dec_id;     // Decoded target
    logic [PROM_AW-1:0] dec_offset; // Decoded byte offset

    // Address decode for the current byte
    always_comb begin
        is_sdram   = ioctl_addr < SDRAM_LIMIT;
        is_prom    = 1'b0;
        dec_id     = PROM_TIMING_7J;
        dec_offset = '0;
        if (!is_sdram && ioctl_addr[21:17] == 5'd0) begin // Above bit 16 is dropped
            if (!ioctl_addr[16]) begin
                // Bit 15 always set here, bits 14:13 pick the OBJ PROM
                is_prom    = 1'b1;
                dec_id     = prom_id_e'(PROM_OBJ_0 + {2'b00, ioctl_addr[14:13]});
                dec_offset = ioctl_addr[12:0];
            end else if (ioctl_addr[12]) begin
                is_prom    = 1'b1;
                dec_offset = {5'd0, ioctl_addr[7:0]}; // 256-byte PROMs
                case (ioctl_addr[9:8])
                    2'd0: dec_id = PROM_TIMING_7J;
                    2'd1: dec_id = PROM_OBJPAL_5B;
                    2'd2: dec_id = PROM_OBJPAL_5A;
                    default: begin
                        // Palettes share a page, bit 5 splits them
                        dec_id     = ioctl_addr[5] ? PROM_BACKPAL_4A : PROM_TXTPAL_3A;
                        dec_offset = {8'd0, ioctl_addr[4:0]};
                    end
                endcase
            end else if (ioctl_addr[11]) begin
                is_prom    = 1'b1;
                dec_id     = PROM_TXT_5N; // Upper half of the text file
                dec_offset = {2'd0, ioctl_addr[10:0]};
            end
            // Bits 12:11 at 00 fall through as a drop
        end
    end

    // Strobes, one destination per byte
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            prog_we      <= 1'b0;
            prom_req_stb <= 1'b0;
            drop_stb     <= 1'b0;
        end else begin
            prog_we      <= ioctl_wr && is_sdram;
            prom_req_stb <= ioctl_wr && is_prom;
            drop_stb     <= ioctl_wr && !is_sdram && !is_prom;
        end
    end

    // Payload registers, held until the next byte of the same kind
    always_ff @(posedge clk_rom) begin
        if (ioctl_wr && is_sdram) begin
            prog <= '{
                addr: {1'b0, ioctl_addr[21:1]},          // Byte address halved
                data: ioctl_data,
                mask: {~ioctl_addr[0], ioctl_addr[0]}    // Even byte enables bit 0
            };
        end
        if (ioctl_wr && is_prom) begin
            prom_req <= '{id: dec_id, offset: dec_offset, data: ioctl_data};
        end
    end

    // Never more than one destination
    a_one_dest: assert property (@(posedge clk_rom) disable iff (rst)
        $onehot0({prog_we, prom_req_stb, drop_stb}))
        else $error("route: more than one destination strobe");

endmodule

// ==== verilog/jtpopeye_xfer_cdc.sv ====
`timescale 1ns/1ps

module jtpopeye_xfer_cdc #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_rom,
    input  logic     clk_rgb,
    input  logic     rst,
    input  payload_t in,
    input  logic     in_stb,
    output logic     busy,
    output payload_t out,
    output logic     out_stb
);

    // clk_rom side
    payload_t hold;     // Stable while the request is in flight
    logic     req_tgl;  // Flips once per payload
    logic     ack_meta; // Acknowledge synchroniser, first stage
    logic     ack_sync; // Acknowledge synchroniser, second stage

    // clk_rgb side
    logic     req_meta; // Request synchroniser, first stage
    logic     req_sync; // Request synchroniser, second stage
    logic     req_seen; // Last request taken, also the acknowledge

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            req_tgl  <= 1'b0;
            ack_meta <= 1'b0;
            ack_sync <= 1'b0;
        end else begin
            ack_meta <= req_seen; // Crosses back from clk_rgb
            ack_sync <= ack_meta;
            if (in_stb) begin
                req_tgl <= ~req_tgl;
            end
        end
    end

    always_ff @(posedge clk_rom) begin
        if (in_stb) begin
            hold <= in;
        end
    end

    assign busy = req_tgl != ack_sync; // Round trip still open

    always_ff @(posedge clk_rgb) begin
        if (rst) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
            req_seen <= 1'b0;
            out_stb  <= 1'b0;
        end else begin
            req_meta <= req_tgl;
            req_sync <= req_meta;
            req_seen <= req_sync;
            out_stb  <= req_sync != req_seen; // One pulse per toggle
        end
    end

    // Output register, hold has been stable for two clk_rgb edges
    always_ff @(posedge clk_rgb) begin
        if (req_sync != req_seen) begin
            out <= hold;
        end
    end

    // Loader must respect the strobe spacing
    a_no_overrun: assert property (@(posedge clk_rom) disable iff (rst)
        in_stb |-> !busy)
        else $error("xfer_cdc: new payload while the previous one is in flight");

endmodule
